//--- design/timer_pkg.sv
package timer_pkg;

    // event FIFO geometry, depth is a power of two.
    localparam int EVT_FIFO_DEPTH = 4;
    localparam int EVT_PTR_W      = 2;

    typedef logic [15:0] count_t; // counter, period and compare values.
    typedef logic [7:0]  presc_t; // prescale divisor minus one.
    typedef logic [7:0]  seq_t;   // event sequence number.

    // 2'b00 is not named and runs as periodic.
    typedef enum logic [1:0] {
        MODE_ONESHOT  = 2'b01,
        MODE_PERIODIC = 2'b10,
        MODE_PWM      = 2'b11
    } timer_mode_t;

    typedef enum logic [2:0] {
        OFF     = 3'b000,
        LOAD    = 3'b001,
        RUN     = 3'b010,
        TIMEOUT = 3'b011,
        RELOAD  = 3'b100
    } timer_state_t;

    // 42 bits, sampled by the counter at start.
    typedef struct packed {
        timer_mode_t mode;
        presc_t      prescale;
        count_t      period;
        count_t      compare;
    } timer_cfg_t;

    // one record per counter expiry.
    typedef struct packed {
        seq_t        seq;
        timer_mode_t mode;
    } timer_event_t;

endpackage

//--- design/timer_fsm.sv
`timescale 1ns/1ps

module timer_fsm import timer_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        start,
    input  logic        stop,
    input  logic        counter_zero,
    input  timer_mode_t mode,
    output logic        prescaler_enable,
    output logic        cnt_load,
    output logic        cnt_enable,
    output logic        cnt_reload_on_zero,
    output logic        busy
);

    timer_state_t state, next_state;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= OFF;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            OFF: begin
                if (start) next_state = LOAD;
            end
            LOAD: next_state = RUN;
            RUN: begin
                if (counter_zero) begin
                    if (mode == MODE_ONESHOT) next_state = TIMEOUT;
                    else                      next_state = RELOAD;
                end
            end
            RELOAD:  next_state = RUN;
            TIMEOUT: next_state = OFF;
            default: next_state = OFF;
        endcase
        if (stop) next_state = OFF; // stop wins over everything.
    end

    always_comb begin
        prescaler_enable   = 1'b0;
        cnt_load           = 1'b0;
        cnt_enable         = 1'b0;
        cnt_reload_on_zero = 1'b0;
        case (state)
            LOAD: begin
                cnt_load = 1'b1;
            end
            RUN: begin
                prescaler_enable   = 1'b1;
                cnt_enable         = 1'b1;
                cnt_reload_on_zero = (mode != MODE_ONESHOT);
            end
            RELOAD: begin
                // prescaler restarts from zero for the next period.
                cnt_load           = 1'b1;
                cnt_reload_on_zero = 1'b1;
            end
            default: begin
            end
        endcase
    end

    assign busy = (state != OFF);

    a_load_excl_enable: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(cnt_load && cnt_enable)
    ) else $error("cnt_load and cnt_enable high together");

    // the counter may only report expiry while the FSM is counting.
    a_zero_in_run: assert property (
        @(posedge clk) disable iff (!rst_n)
        counter_zero |-> state == RUN
    ) else $error("counter_zero outside RUN");

endmodule

//--- design/timer_prescaler.sv
`timescale 1ns/1ps

module timer_prescaler import timer_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   enable,
    input  presc_t prescale,
    output logic   tick
);

    presc_t div_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= '0;
        end else if (!enable) begin
            div_cnt <= '0; // hold at zero while idle.
        end else if (div_cnt == prescale) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // one tick every prescale+1 enabled cycles.
    assign tick = enable && (div_cnt == prescale);

    // a divided tick needs enable held through the whole division.
    a_tick_enabled: assert property (
        @(posedge clk) disable iff (!rst_n)
        tick |-> enable && (prescale == '0 || $past(enable))
    ) else $error("prescaler tick without enable");

endmodule

//--- design/timer_counter.sv
`timescale 1ns/1ps

module timer_counter import timer_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  timer_cfg_t   cfg,
    input  logic         load,
    input  logic         enable,
    input  logic         reload_on_zero,
    input  logic         tick,
    output logic         counter_zero,
    output logic         pwm_out,
    output logic         push_valid,
    output timer_event_t push_evt
);

    timer_cfg_t cfg_q;
    count_t     count;
    seq_t       seq;
    logic       running; // load or enable seen last cycle.
    logic       first_load;

    // a load with no activity the cycle before comes from start.
    assign first_load = load && !running;

    always_ff @(posedge clk) begin
        if (first_load) cfg_q <= cfg;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count   <= '0;
            seq     <= '0;
            running <= 1'b0;
        end else begin
            running <= load | enable;
            if (load) begin
                if (first_load) begin
                    count <= cfg.period;
                    seq   <= '0;
                end else begin
                    count <= cfg_q.period; // reload keeps the sampled config.
                end
            end else if (enable && tick) begin
                if (count != '0) begin
                    count <= count - 1'b1;
                end else begin
                    seq <= seq + 1'b1;
                    if (reload_on_zero) count <= cfg_q.period;
                end
            end
        end
    end

    assign counter_zero = enable && tick && (count == '0);

    // offered for this cycle only, lost if the FIFO is full.
    assign push_valid    = counter_zero;
    assign push_evt.seq  = seq;
    assign push_evt.mode = cfg_q.mode;

    assign pwm_out = enable && (cfg_q.mode == MODE_PWM) && (count < cfg_q.compare);

    // every expiry leaves RUN, so two events never come back to back.
    a_push_single: assert property (
        @(posedge clk) disable iff (!rst_n)
        push_valid |=> !push_valid
    ) else $error("event offered on consecutive cycles");

endmodule

//--- design/timer_event_fifo.sv
`timescale 1ns/1ps

module timer_event_fifo import timer_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         push_valid,
    input  timer_event_t push_evt,
    output logic         push_ready,
    output logic         pop_valid,
    output timer_event_t pop_evt,
    input  logic         pop_ready,
    output logic         overflow
);

    timer_event_t           mem [EVT_FIFO_DEPTH];
    logic [EVT_PTR_W-1:0]   wr_ptr;
    logic [EVT_PTR_W-1:0]   rd_ptr;
    logic [EVT_PTR_W:0]     fill;
    logic                   do_push;
    logic                   do_pop;

    assign push_ready = (fill != (EVT_PTR_W + 1)'(EVT_FIFO_DEPTH));
    assign pop_valid  = (fill != '0);
    assign do_push    = push_valid && push_ready;
    assign do_pop     = pop_valid && pop_ready;

    assign pop_evt = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= push_evt;
    end

    // pointers wrap on their own width.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            overflow <= 1'b0;
        end else if (push_valid && !push_ready) begin
            overflow <= 1'b1; // sticky until reset.
        end
    end

    a_pop_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        pop_valid && !pop_ready |=> pop_valid && $stable(pop_evt)
    ) else $error("event changed while stalled");

endmodule

//--- design/timer_top.sv
`timescale 1ns/1ps

module timer_top import timer_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  timer_cfg_t   cfg,
    input  logic         start,
    input  logic         stop,
    output logic         evt_valid,
    output timer_event_t evt,
    input  logic         evt_ready,
    output logic         pwm_out,
    output logic         busy,
    output logic         overflow
);

    logic         prescaler_enable;
    logic         cnt_load;
    logic         cnt_enable;
    logic         cnt_reload_on_zero;
    logic         tick;
    logic         counter_zero;
    logic         push_valid;
    timer_event_t push_evt;

    timer_fsm u_fsm (
        .clk                (clk),
        .rst_n              (rst_n),
        .start              (start),
        .stop               (stop),
        .counter_zero       (counter_zero),
        .mode               (cfg.mode),
        .prescaler_enable   (prescaler_enable),
        .cnt_load           (cnt_load),
        .cnt_enable         (cnt_enable),
        .cnt_reload_on_zero (cnt_reload_on_zero),
        .busy               (busy)
    );

    timer_prescaler u_prescaler (
        .clk      (clk),
        .rst_n    (rst_n),
        .enable   (prescaler_enable),
        .prescale (cfg.prescale),
        .tick     (tick)
    );

    timer_counter u_counter (
        .clk            (clk),
        .rst_n          (rst_n),
        .cfg            (cfg),
        .load           (cnt_load),
        .enable         (cnt_enable),
        .reload_on_zero (cnt_reload_on_zero),
        .tick           (tick),
        .counter_zero   (counter_zero),
        .pwm_out        (pwm_out),
        .push_valid     (push_valid),
        .push_evt       (push_evt)
    );

    // a push the FIFO cannot take is lost and sets overflow.
    timer_event_fifo u_evt_fifo (
        .clk        (clk),
        .rst_n      (rst_n),
        .push_valid (push_valid),
        .push_evt   (push_evt),
        .push_ready (),
        .pop_valid  (evt_valid),
        .pop_evt    (evt),
        .pop_ready  (evt_ready),
        .overflow   (overflow)
    );

endmodule

//--- tb/timer_tb.sv
`timescale 1ns/1ps

module timer_tb import timer_pkg::*; ();

    logic         clk;
    logic         rst_n;
    timer_cfg_t   cfg;
    logic         start;
    logic         stop;
    logic         evt_valid;
    timer_event_t evt;
    logic         evt_ready = 1'b0;
    logic         pwm_out;
    logic         busy;
    logic         overflow;

    int          seed = 30;
    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          test_errors = 0; // error count when the current test began.
    string       test_name = "none";
    int          pops = 0;
    int          pop_base = 0;
    int          pwm_cycles = 0;
    int          pwm_base = 0;
    seq_t        exp_q[$];        // sequence numbers the host still expects.
    seq_t        exp_seq = '0;
    int          exp_left = 0;
    timer_mode_t exp_mode;
    logic [1:0]  ready_mode;      // 0 held low, 1 held high, 2 random.
    logic        allow_gap;
    logic        idle_check;

    timer_top DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg       (cfg),
        .start     (start),
        .stop      (stop),
        .evt_valid (evt_valid),
        .evt       (evt),
        .evt_ready (evt_ready),
        .pwm_out   (pwm_out),
        .busy      (busy),
        .overflow  (overflow)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        case (ready_mode)
            2'd0:    evt_ready <= 1'b0;
            2'd1:    evt_ready <= 1'b1;
            default: evt_ready <= 1'($random(seed));
        endcase
    end

    // host side, consumes the expected queue as events are taken.
    always @(posedge clk) begin
        if (rst_n && evt_valid && evt_ready) begin
            if (allow_gap && overflow) begin
                while (exp_q.size() > 0 && exp_q[0] != evt.seq) begin
                    void'(exp_q.pop_front()); // lost to overflow.
                end
            end
            if (exp_q.size() > 0) begin
                void'(exp_q.pop_front());
            end
            pops <= pops + 1;
        end
        if (pwm_out) pwm_cycles <= pwm_cycles + 1;
        exp_left <= exp_q.size();
        exp_seq  <= (exp_q.size() > 0) ? exp_q[0] : '0;
    end

    a_idle_after_reset: assert property (
        @(posedge clk) disable iff (!rst_n)
        idle_check |-> !evt_valid && !busy && !pwm_out && !overflow
    ) else begin
        $display("test %s: outputs not idle after reset", test_name);
        errors++;
    end

    a_event_expected: assert property (
        @(posedge clk) disable iff (!rst_n)
        evt_valid && evt_ready |-> exp_left != 0
    ) else begin
        $display("test %s: event delivered when none was expected", test_name);
        errors++;
    end

    // a gap is only legal once an event has been dropped.
    a_seq_order: assert property (
        @(posedge clk) disable iff (!rst_n)
        evt_valid && evt_ready && exp_left != 0
            |-> evt.seq == exp_seq || (allow_gap && overflow && evt.seq > exp_seq)
    ) else begin
        $display("Mismatch: test %s seq expected %0d actual %0d",
                 test_name, $sampled(exp_seq), $sampled(evt.seq));
        errors++;
    end

    a_mode: assert property (
        @(posedge clk) disable iff (!rst_n)
        evt_valid && evt_ready |-> evt.mode == exp_mode
    ) else begin
        $display("Mismatch: test %s mode expected %0d actual %0d",
                 test_name, $sampled(exp_mode), $sampled(evt.mode));
        errors++;
    end

    a_stall_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        evt_valid && !evt_ready |=> evt_valid && $stable(evt)
    ) else begin
        $display("test %s: stalled event changed or vanished", test_name);
        errors++;
    end

    a_quiet_when_idle: assert property (
        @(posedge clk) disable iff (!rst_n)
        !busy && !$past(busy) |-> !$rose(evt_valid)
    ) else begin
        $display("test %s: new event appeared while the timer was idle", test_name);
        errors++;
    end

    a_pwm_mode: assert property (
        @(posedge clk) disable iff (!rst_n)
        pwm_out |-> busy && cfg.mode == MODE_PWM
    ) else begin
        $display("test %s: pwm_out high outside a PWM run", test_name);
        errors++;
    end

    a_pwm_cmp_zero: assert property (
        @(posedge clk) disable iff (!rst_n)
        cfg.compare == '0 |-> !pwm_out
    ) else begin
        $display("test %s: pwm_out high with compare zero", test_name);
        errors++;
    end

    // each event spans period+1 ticks of prescale+1 cycles.
    function automatic int run_budget(input int events, input int period, input int prescale);
        return events * (period + 1) * (prescale + 1) + 20;
    endfunction

    task automatic apply_reset();
        rst_n <= 1'b0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
    endtask

    task automatic begin_test(input string name, input timer_mode_t mode, input int count);
        int i;
        test_name   = name;
        test_errors = errors;
        pop_base    = pops;
        pwm_base    = pwm_cycles;
        exp_mode    = mode;
        exp_q.delete();
        for (i = 0; i < count; i++) begin
            exp_q.push_back(seq_t'(i));
        end
        @(posedge clk);
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == test_errors) begin
            $display("test %s: pass", test_name);
        end else begin
            tests_failed++;
            $display("test %s: fail, %0d errors", test_name, errors - test_errors);
        end
    endtask

    task automatic start_timer(input timer_mode_t new_mode, input presc_t new_prescale,
                               input count_t new_period, input count_t new_compare);
        cfg <= '{mode: new_mode, prescale: new_prescale,
                 period: new_period, compare: new_compare};
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(posedge clk); // FSM is in RUN from here.
    endtask

    task automatic wait_idle();
        while (busy) begin
            @(posedge clk);
        end
    endtask

    task automatic stop_timer();
        stop <= 1'b1;
        @(posedge clk);
        stop <= 1'b0;
        @(posedge clk);
        wait_idle();
    endtask

    task automatic wait_pops(input int count);
        while (pops - pop_base < count) begin
            @(posedge clk);
        end
    endtask

    task automatic wait_drained();
        while (evt_valid) begin
            @(posedge clk);
        end
    endtask

    task automatic wait_interval(input int period, input int prescale, input int extra);
        repeat ((period + 1) * (prescale + 1) + extra) @(posedge clk);
    endtask

    task automatic check_count(input string what, input int expected, input int actual);
        assert (actual == expected) else begin
            $display("Mismatch: test %s %s expected %0d actual %0d",
                     test_name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic check_true(input string what, input bit cond);
        assert (cond) else begin
            $display("test %s: %s did not hold", test_name, what);
            errors++;
        end
    endtask

    initial begin
        int limit;
        limit = 2 * (run_budget(0, 0, 0) + run_budget(1, 4, 1) + run_budget(5, 3, 1)
                   + run_budget(6, 2, 0) + run_budget(16, 1, 0) + run_budget(3, 5, 1)
                   + run_budget(2, 3, 0));
        repeat (limit) @(posedge clk);
        $display("watchdog: run did not finish within %0d cycles", limit);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        rst_n      = 1'b0;
        cfg        = '0;
        start      = 1'b0;
        stop       = 1'b0;
        ready_mode = 2'd1;
        allow_gap  = 1'b0;
        idle_check = 1'b0;
        exp_mode   = MODE_PERIODIC;

        apply_reset();
        begin_test("reset", MODE_PERIODIC, 0);
        idle_check <= 1'b1;
        repeat (3) @(posedge clk);
        idle_check <= 1'b0;
        end_test();

        begin_test("oneshot", MODE_ONESHOT, 1);
        start_timer(MODE_ONESHOT, 8'd1, 16'd4, 16'd3);
        wait_idle(); // ends on its own, no stop.
        wait_pops(1);
        wait_interval(4, 1, 4);
        check_count("events", 1, pops - pop_base);
        end_test();

        begin_test("periodic", MODE_PERIODIC, 5);
        start_timer(MODE_PERIODIC, 8'd1, 16'd3, 16'd2);
        wait_pops(5);
        stop_timer();
        wait_drained();
        wait_interval(3, 1, 4);
        check_count("events", 5, pops - pop_base);
        end_test();

        begin_test("backpressure", MODE_PERIODIC, 4);
        ready_mode <= 2'd0;
        start_timer(MODE_PERIODIC, 8'd0, 16'd2, 16'd0);
        while (!overflow) begin
            @(posedge clk);
        end
        wait_interval(2, 0, 1); // sixth expiry, also dropped.
        stop_timer();
        check_count("overflow", 1, overflow);
        ready_mode <= 2'd1;
        wait_pops(4);
        wait_drained();
        wait_interval(2, 0, 4);
        check_count("events", 4, pops - pop_base);
        end_test();

        apply_reset(); // clears the sticky overflow.
        begin_test("random_ready", MODE_PERIODIC, 64);
        allow_gap  <= 1'b1;
        ready_mode <= 2'd2;
        start_timer(MODE_PERIODIC, 8'd0, 16'd1, 16'd0);
        wait_pops(12);
        stop_timer();
        ready_mode <= 2'd1;
        @(posedge clk);
        wait_drained();
        wait_interval(1, 0, 4);
        allow_gap <= 1'b0;
        end_test();

        begin_test("pwm", MODE_PWM, 3);
        start_timer(MODE_PWM, 8'd1, 16'd5, 16'd3);
        wait_pops(3);
        stop_timer();
        wait_drained();
        wait_interval(5, 1, 4);
        check_count("events", 3, pops - pop_base);
        check_true("pwm_out high during the run", pwm_cycles > pwm_base);
        end_test();

        begin_test("pwm_compare_zero", MODE_PWM, 2);
        start_timer(MODE_PWM, 8'd0, 16'd3, 16'd0);
        wait_pops(2);
        stop_timer();
        wait_drained();
        wait_interval(3, 0, 4);
        check_count("events", 2, pops - pop_base);
        check_count("pwm high cycles", 0, pwm_cycles - pwm_base);
        end_test();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
design/timer_pkg.sv
design/timer_fsm.sv
design/timer_prescaler.sv
design/timer_counter.sv
design/timer_event_fifo.sv
design/timer_top.sv
tb/timer_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := timer_tb
RTL_TOP    := timer_top
FILELIST   := verilog.f
COMMON     := --timing --assert --timescale 1ns/1ps
LINT_FLAGS := --lint-only $(COMMON)
SIM_FLAGS  := --binary -j 0 $(COMMON)
BUILD_DIR  := obj_dir
LOG        := sim.log
FAIL_MSG   := CHECKS FAILED
PASS_MSG   := ALL CHECKS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
